// ==== src/core_params.svh ====
//==========================================================
// core width macros
//==========================================================
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths of the rv32 core
`define DATA_WIDTH	32		// operand and result width
`define ADDR_WIDTH	`DATA_WIDTH	// data memory address width
`define SHAMT_WIDTH	5		// shift amount taken from src2
`define RD_WIDTH	5		// register index without the none bit

// reset and bubble values
`define RD_NONE		32		// rd with only the top bit set
`define DATA_RST	0		// result and store data after reset

`endif

// ==== src/core_types_pkg.sv ====
//==========================================================
// core vector types
//==========================================================
`include "core_params.svh"

package core_types_pkg;

	// operand or result of the datapath
	typedef logic [`DATA_WIDTH-1:0] data_t;

	// byte address into data memory
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// destination index, msb set means no write back
	typedef logic [`RD_WIDTH:0] rd_t;

	// shift amount for sll, srl and sra
	typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

endpackage

// ==== src/ex_ctrl_pkg.sv ====
//==========================================================
// execute stage control bundles
//==========================================================
`include "core_params.svh"

package ex_ctrl_pkg;

	import core_types_pkg::*;

	// one-hot operation strobes from the decoder
	typedef struct packed {
		logic add;		// rs1 + rs2
		logic sub;		// rs1 - rs2
		logic slt;		// signed less than
		logic sltu;		// unsigned less than
		logic and_op;		// bitwise and
		logic or_op;		// bitwise or
		logic xor_op;		// bitwise xor
		logic sll;		// shift left logical
		logic srl;		// shift right logical
		logic sra;		// shift right arithmetic
		logic mul;		// low half of product
		logic mulh;		// high half, signed x signed
		logic mulhsu;		// high half, signed x unsigned
		logic mulhu;		// high half, unsigned x unsigned
		logic src2_only;	// lui and jump link bypass
	} alu_ctrl_t;

	// multiply strobes seen by the multiplier
	typedef struct packed {
		logic mul;
		logic mulh;
		logic mulhsu;
		logic mulhu;
	} mul_ctrl_t;

	// branch condition strobes
	typedef struct packed {
		logic beq;		// rs1 == rs2
		logic bne;		// rs1 != rs2
		logic blt;		// signed rs1 < rs2
		logic bge;		// signed rs1 >= rs2
		logic bltu;		// unsigned rs1 < rs2
		logic bgeu;		// unsigned rs1 >= rs2
	} br_ctrl_t;

	// memory access controls
	typedef struct packed {
		logic load;		// load instruction
		logic store;		// store instruction
		logic mem_h;		// halfword access
		logic mem_b;		// byte access
		logic mem_u;		// zero extend loaded half or byte
	} mem_ctrl_t;

	// everything the MEM stage takes from EX
	typedef struct packed {
		data_t result;		// alu result, also the address
		rd_t rd;		// destination register
		mem_ctrl_t ctrl;	// access type
		data_t store_data;	// rs2 value for stores
	} mem_stage_t;

	// empty slot, used at reset and for bubbles
	localparam mem_stage_t MEM_BUBBLE = '{
		result: data_t'(`DATA_RST),
		rd: rd_t'(`RD_NONE),
		ctrl: '0,
		store_data: data_t'(`DATA_RST)
	};

endpackage

// ==== src/mul_unit.sv ====
//==========================================================
// single cycle multiplier
//==========================================================
`timescale 1ns/100ps
`include "core_params.svh"

module mul_unit (
	input  core_types_pkg::data_t	src1_i,		// multiplicand
	input  core_types_pkg::data_t	src2_i,		// multiplier
	input  ex_ctrl_pkg::mul_ctrl_t	mul_ctrl_i,	// which multiply, at most one set
	output core_types_pkg::data_t	mul_result_o	// selected product half
);

	import core_types_pkg::*;

	logic src1_signed;			// src1 read as two's complement
	logic src2_signed;			// src2 read as two's complement
	logic src1_neg;				// src1 is a negative signed value
	logic src2_neg;				// src2 is a negative signed value
	data_t src1_mag;			// absolute value of src1
	data_t src2_mag;			// absolute value of src2
	logic prod_neg;				// product needs its sign restored
	logic use_high;				// one of the high half ops
	logic [2*`DATA_WIDTH-1:0] prod_mag;	// unsigned product of magnitudes
	logic [2*`DATA_WIDTH-1:0] prod;		// signed product

	// mulhu treats both unsigned, mulhsu only src2
	assign src1_signed = mul_ctrl_i.mul | mul_ctrl_i.mulh | mul_ctrl_i.mulhsu;
	assign src2_signed = mul_ctrl_i.mul | mul_ctrl_i.mulh;

	assign src1_neg = src1_signed & src1_i[`DATA_WIDTH-1];
	assign src2_neg = src2_signed & src2_i[`DATA_WIDTH-1];

	// most negative value maps onto 2^31, still fits unsigned
	assign src1_mag = src1_neg ? (~src1_i + 1'b1) : src1_i;
	assign src2_mag = src2_neg ? (~src2_i + 1'b1) : src2_i;

	assign prod_mag = {{`DATA_WIDTH{1'b0}}, src1_mag} * {{`DATA_WIDTH{1'b0}}, src2_mag};

	// a zero operand gives a positive zero
	assign prod_neg = (src1_neg ^ src2_neg) & (|src1_i) & (|src2_i);
	assign prod = prod_neg ? (~prod_mag + 1'b1) : prod_mag;

	assign use_high = mul_ctrl_i.mulh | mul_ctrl_i.mulhsu | mul_ctrl_i.mulhu;

	// low half for mul, upper half otherwise, zero with no strobe
	assign mul_result_o = ({`DATA_WIDTH{mul_ctrl_i.mul}} & prod[`DATA_WIDTH-1:0])
		| ({`DATA_WIDTH{use_high}} & prod[2*`DATA_WIDTH-1:`DATA_WIDTH]);

endmodule

// ==== src/alu_core.sv ====
//==========================================================
// integer alu with multiplier
//==========================================================
`timescale 1ns/100ps
`include "core_params.svh"

module alu_core (
	input  core_types_pkg::data_t	src1_i,		// rs1 value or pc
	input  core_types_pkg::data_t	src2_i,		// rs2 value or immediate
	input  ex_ctrl_pkg::alu_ctrl_t	alu_ctrl_i,	// one-hot operation select
	output core_types_pkg::data_t	alu_result_o	// result, also forwarded to dec
);

	import core_types_pkg::*;
	import ex_ctrl_pkg::*;

	shamt_t shamt;				// low bits of src2
	data_t adder_b;				// src2 or its inverse for sub
	data_t adder_res;			// shared add and sub result
	data_t slt_res;
	data_t sltu_res;
	data_t and_res;
	data_t or_res;
	data_t xor_res;
	data_t sll_res;
	data_t srl_res;
	data_t sra_res;
	logic signed [`DATA_WIDTH-1:0] sra_full;	// ungated arithmetic shift
	mul_ctrl_t mul_ctrl;			// multiply strobes only
	data_t mul_res;				// already gated inside mul_unit
	data_t op_res;				// merge of all gated results

	// one adder, sub uses a + ~b + 1
	assign adder_b = alu_ctrl_i.sub ? ~src2_i : src2_i;
	assign adder_res = (alu_ctrl_i.add | alu_ctrl_i.sub) ?
		(src1_i + adder_b + alu_ctrl_i.sub) : '0;

	// set-less-than yields 0 or 1
	assign slt_res = {{(`DATA_WIDTH-1){1'b0}},
		alu_ctrl_i.slt & ($signed(src1_i) < $signed(src2_i))};
	assign sltu_res = {{(`DATA_WIDTH-1){1'b0}}, alu_ctrl_i.sltu & (src1_i < src2_i)};

	assign and_res = alu_ctrl_i.and_op ? (src1_i & src2_i) : '0;
	assign or_res  = alu_ctrl_i.or_op  ? (src1_i | src2_i) : '0;
	assign xor_res = alu_ctrl_i.xor_op ? (src1_i ^ src2_i) : '0;

	assign shamt = src2_i[`SHAMT_WIDTH-1:0];

	assign sll_res = alu_ctrl_i.sll ? (src1_i << shamt) : '0;
	assign srl_res = alu_ctrl_i.srl ? (src1_i >> shamt) : '0;

	// kept apart from the gate so the shift stays signed
	assign sra_full = $signed(src1_i) >>> shamt;
	assign sra_res = alu_ctrl_i.sra ? data_t'(sra_full) : '0;

	assign mul_ctrl = '{
		mul: alu_ctrl_i.mul,
		mulh: alu_ctrl_i.mulh,
		mulhsu: alu_ctrl_i.mulhsu,
		mulhu: alu_ctrl_i.mulhu
	};

	mul_unit mul_unit_i (
		.src1_i		(src1_i),
		.src2_i		(src2_i),
		.mul_ctrl_i	(mul_ctrl),
		.mul_result_o	(mul_res)
	);

	// unselected ops are zero so a plain or picks the one result
	assign op_res = adder_res | slt_res | sltu_res | and_res | or_res | xor_res
		| sll_res | srl_res | sra_res | mul_res;

	// lui and jal/jalr link value pass src2 through
	assign alu_result_o = alu_ctrl_i.src2_only ? src2_i : op_res;

endmodule

// ==== src/branch_cond.sv ====
//==========================================================
// branch condition check
//==========================================================
`timescale 1ns/100ps

module branch_cond (
	input  core_types_pkg::data_t	src1_i,		// rs1 value
	input  core_types_pkg::data_t	src2_i,		// rs2 value
	input  ex_ctrl_pkg::br_ctrl_t	br_ctrl_i,	// branch type, at most one set
	output logic			branch_taken_o	// condition met
);

	logic eq;		// rs1 == rs2
	logic lt_s;		// rs1 < rs2 signed
	logic lt_u;		// rs1 < rs2 unsigned
	logic beq_taken;
	logic bne_taken;
	logic blt_taken;
	logic bge_taken;
	logic bltu_taken;
	logic bgeu_taken;

	// comparators independent of the alu strobes
	assign eq   = (src1_i == src2_i);
	assign lt_s = ($signed(src1_i) < $signed(src2_i));
	assign lt_u = (src1_i < src2_i);

	assign beq_taken  = br_ctrl_i.beq  & eq;
	assign bne_taken  = br_ctrl_i.bne  & ~eq;
	assign blt_taken  = br_ctrl_i.blt  & lt_s;
	assign bge_taken  = br_ctrl_i.bge  & ~lt_s;	// ge is not lt
	assign bltu_taken = br_ctrl_i.bltu & lt_u;
	assign bgeu_taken = br_ctrl_i.bgeu & ~lt_u;

	// zero when no branch strobe is set
	assign branch_taken_o = beq_taken | bne_taken | blt_taken | bge_taken
		| bltu_taken | bgeu_taken;

endmodule

// ==== src/ex_mem_reg.sv ====
//==========================================================
// EX to MEM pipeline register
//==========================================================
`timescale 1ns/100ps

module ex_mem_reg (
	input  logic			cpu_clk,	// cpu clock
	input  logic			cpu_rstn,	// async reset, active low
	input  logic			dec_valid_i,	// EX holds a real instruction
	input  logic			mem_ready_i,	// MEM can take a new entry
	input  core_types_pkg::data_t	result_i,	// alu result at EX
	input  core_types_pkg::rd_t	rd_i,		// destination at EX
	input  ex_ctrl_pkg::mem_ctrl_t	mem_ctrl_i,	// memory controls at EX
	input  core_types_pkg::data_t	store_data_i,	// store source at EX
	output logic			ex_valid_o,	// MEM register written at least once
	output ex_ctrl_pkg::mem_stage_t	mem_stage_o,	// registered MEM bundle
	output core_types_pkg::addr_t	mem_addr_o	// data memory address at MEM
);

	import ex_ctrl_pkg::*;

	mem_stage_t mem_next;		// value loaded at the next ready edge

	// no valid instruction from dec turns into a bubble
	always_comb
	begin
		if (dec_valid_i)
		begin
			mem_next = '{
				result: result_i,
				rd: rd_i,
				ctrl: mem_ctrl_i,
				store_data: store_data_i
			};
		end
		else
		begin
			mem_next = MEM_BUBBLE;
		end
	end

	// holds everything while MEM stalls
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			mem_stage_o <= MEM_BUBBLE;
			ex_valid_o <= 1'b0;
		end
		else if (mem_ready_i)
		begin
			mem_stage_o <= mem_next;
			ex_valid_o <= 1'b1;	// sticky once written
		end
	end

	// address only for real accesses, zero keeps the bus quiet
	assign mem_addr_o = (mem_stage_o.ctrl.load | mem_stage_o.ctrl.store) ?
		mem_stage_o.result : '0;

endmodule

// ==== src/ex_stage.sv ====
//==========================================================
// execute stage top
//==========================================================
`timescale 1ns/100ps

module ex_stage (
	input  logic			cpu_clk,	// cpu clock
	input  logic			cpu_rstn,	// async reset, active low
	input  logic			dec_valid_i,	// operands from dec are valid
	input  core_types_pkg::data_t	src1_i,		// source 1 at EX
	input  core_types_pkg::data_t	src2_i,		// source 2 at EX
	input  ex_ctrl_pkg::alu_ctrl_t	alu_ctrl_i,	// alu operation strobes
	input  ex_ctrl_pkg::br_ctrl_t	br_ctrl_i,	// branch strobes
	input  ex_ctrl_pkg::mem_ctrl_t	mem_ctrl_i,	// memory access controls
	input  core_types_pkg::data_t	store_data_i,	// store source data
	input  core_types_pkg::rd_t	rd_i,		// destination at EX
	input  logic			mem_ready_i,	// MEM stage ready level
	output logic			ex_ready_o,	// EX can accept from dec
	output core_types_pkg::data_t	alu_result_o,	// EX result, forwarded to dec
	output logic			branch_taken_o,	// branch condition met
	output logic			ex_valid_o,	// MEM register written
	output ex_ctrl_pkg::mem_stage_t	mem_stage_o,	// bundle at MEM
	output core_types_pkg::addr_t	mem_addr_o	// memory address at MEM
);

	import core_types_pkg::*;

	data_t alu_result;		// shared by output and MEM register

	alu_core alu_core_i (
		.src1_i		(src1_i),
		.src2_i		(src2_i),
		.alu_ctrl_i	(alu_ctrl_i),
		.alu_result_o	(alu_result)
	);

	branch_cond branch_cond_i (
		.src1_i		(src1_i),
		.src2_i		(src2_i),
		.br_ctrl_i	(br_ctrl_i),
		.branch_taken_o	(branch_taken_o)
	);

	ex_mem_reg ex_mem_reg_i (
		.cpu_clk	(cpu_clk),
		.cpu_rstn	(cpu_rstn),
		.dec_valid_i	(dec_valid_i),
		.mem_ready_i	(mem_ready_i),
		.result_i	(alu_result),
		.rd_i		(rd_i),
		.mem_ctrl_i	(mem_ctrl_i),
		.store_data_i	(store_data_i),
		.ex_valid_o	(ex_valid_o),
		.mem_stage_o	(mem_stage_o),
		.mem_addr_o	(mem_addr_o)
	);

	assign alu_result_o = alu_result;
	assign ex_ready_o = mem_ready_i;	// single cycle EX only stalls on MEM

endmodule

// ==== tb/ex_stage_assert.sv ====
//==========================================================
// ex stage checker
//==========================================================
`timescale 1ns/100ps
`include "core_params.svh"

module ex_stage_assert (
	input  logic			cpu_clk,
	input  logic			cpu_rstn,
	input  core_types_pkg::data_t	src1_i,
	input  core_types_pkg::data_t	src2_i,
	input  ex_ctrl_pkg::alu_ctrl_t	alu_ctrl_i,
	input  ex_ctrl_pkg::br_ctrl_t	br_ctrl_i,
	input  logic			mem_ready_i,
	input  logic			ex_ready_o,
	input  core_types_pkg::data_t	alu_result_o,
	input  logic			branch_taken_o,
	input  logic			ex_valid_o,
	input  ex_ctrl_pkg::mem_stage_t	mem_stage_o,
	input  core_types_pkg::addr_t	mem_addr_o
);

	import core_types_pkg::*;
	import ex_ctrl_pkg::*;

	int unsigned fail_count = 0;	// watched from the testbench
	data_t exp_result;		// rv32im result of the selected op
	logic exp_taken;		// expected branch decision

	// rv32im semantics, at most one strobe set
	function automatic data_t ref_alu(data_t a, data_t b, alu_ctrl_t op);
		logic [63:0] a_s;	// sign extended
		logic [63:0] b_s;
		logic [63:0] a_u;	// zero extended
		logic [63:0] b_u;
		data_t res;
		a_s = {{32{a[31]}}, a};
		b_s = {{32{b[31]}}, b};
		a_u = {32'h0, a};
		b_u = {32'h0, b};
		res = 32'h0;
		if (op.add) res = a + b;
		if (op.sub) res = a - b;
		if (op.slt) res = data_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));	// biased compare
		if (op.sltu) res = data_t'(a < b);
		if (op.and_op) res = a & b;
		if (op.or_op) res = a | b;
		if (op.xor_op) res = a ^ b;
		if (op.sll) res = a << b[4:0];
		if (op.srl) res = a >> b[4:0];
		if (op.sra) res = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
		if (op.mul) res = data_t'(a_u * b_u);	// low half is sign independent
		if (op.mulh) res = data_t'((a_s * b_s) >> 32);	// mod 2^64 keeps the sign
		if (op.mulhsu) res = data_t'((a_s * b_u) >> 32);
		if (op.mulhu) res = data_t'((a_u * b_u) >> 32);
		if (op.src2_only) res = b;	// lui and link value
		return res;
	endfunction

	function automatic logic ref_branch(data_t a, data_t b, br_ctrl_t br);
		logic lt_s;
		lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);	// sign flip gives signed order
		return (br.beq & (a == b)) | (br.bne & (a != b)) | (br.blt & lt_s)
			| (br.bge & !lt_s) | (br.bltu & (a < b)) | (br.bgeu & (a >= b));
	endfunction

	task automatic flag_failure(input string msg);
		fail_count++;		// lets the testbench stop the run
		$error("%s", msg);
	endtask

	assign exp_result = ref_alu(src1_i, src2_i, alu_ctrl_i);
	assign exp_taken = ref_branch(src1_i, src2_i, br_ctrl_i);

	// EX outputs are combinational, inputs settle on the falling edge
	result_ok: assert property (@(posedge cpu_clk) alu_result_o == exp_result)
		else flag_failure($sformatf("Fail alu_result_o exp %h got %h", exp_result, alu_result_o));
	branch_ok: assert property (@(posedge cpu_clk) branch_taken_o == exp_taken)
		else flag_failure($sformatf("Fail branch_taken_o exp %h got %h", exp_taken, branch_taken_o));
	ready_ok: assert property (@(posedge cpu_clk) ex_ready_o == mem_ready_i)
		else flag_failure($sformatf("Fail ex_ready_o exp %h got %h", mem_ready_i, ex_ready_o));

	// empty MEM slot while reset is held
	reset_ok: assert property (@(posedge cpu_clk) !cpu_rstn |=> !ex_valid_o
		&& mem_stage_o.rd == rd_t'(`RD_NONE) && mem_stage_o.ctrl == 5'h0
		&& mem_stage_o.result == 32'h0 && mem_stage_o.store_data == 32'h0)
		else flag_failure("MEM register not empty after reset");

	// back-pressure freezes the whole MEM side
	hold_ok: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		!mem_ready_i |=> $stable(mem_stage_o) && $stable(ex_valid_o) && $stable(mem_addr_o))
		else flag_failure("MEM outputs changed while mem_ready_i was low");

endmodule

// checker rides on every ex_stage instance
bind ex_stage ex_stage_assert ex_stage_assert_i (.*);

// ==== tb/ex_stage_tb.sv ====
//==========================================================
// ex stage testbench
//==========================================================
`timescale 1ns/100ps
`include "core_params.svh"

module ex_stage_tb;

	import core_types_pkg::*;
	import ex_ctrl_pkg::*;

	localparam int CORNER_CNT = 4;
	localparam int DIRECTED_OPS = 15 * CORNER_CNT * CORNER_CNT;	// each strobe, each pair
	localparam int RANDOM_OPS = 300;

	logic cpu_clk;
	logic cpu_rstn;
	logic dec_valid;
	data_t src1;
	data_t src2;
	alu_ctrl_t alu_ctrl;
	br_ctrl_t br_ctrl;
	mem_ctrl_t mem_ctrl;
	data_t store_data;
	rd_t rd;
	logic mem_ready;
	logic ex_ready;
	data_t alu_result;
	logic branch_taken;
	logic ex_valid;
	mem_stage_t mem_stage;
	addr_t mem_addr;

	mem_stage_t exp_mem;		// one entry model of the MEM register
	logic exp_valid;		// MEM register written since reset
	data_t corner [CORNER_CNT] = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h0000_001f};

	ex_stage dut_i (
		.cpu_clk	(cpu_clk),
		.cpu_rstn	(cpu_rstn),
		.dec_valid_i	(dec_valid),
		.src1_i		(src1),
		.src2_i		(src2),
		.alu_ctrl_i	(alu_ctrl),
		.br_ctrl_i	(br_ctrl),
		.mem_ctrl_i	(mem_ctrl),
		.store_data_i	(store_data),
		.rd_i		(rd),
		.mem_ready_i	(mem_ready),
		.ex_ready_o	(ex_ready),
		.alu_result_o	(alu_result),
		.branch_taken_o	(branch_taken),
		.ex_valid_o	(ex_valid),
		.mem_stage_o	(mem_stage),
		.mem_addr_o	(mem_addr)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #5 cpu_clk = ~cpu_clk;	// 10 ns period
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_hex(input string name, input logic [79:0] exp, input logic [79:0] got);
		if (got !== exp)
			stop_on_error($sformatf("Fail %s exp %h got %h", name, exp, got));
	endtask

	function automatic mem_stage_t bubble_entry();
		return '{result: 32'h0, rd: rd_t'(`RD_NONE), ctrl: 5'h0, store_data: 32'h0};
	endfunction

	// advances on the same edges as the DUT register
	always @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			exp_mem = bubble_entry();
			exp_valid = 1'b0;
		end
		else if (mem_ready)
		begin
			exp_valid = 1'b1;	// sticky once written
			if (dec_valid)
				exp_mem = '{result: dut_i.ex_stage_assert_i.exp_result, rd: rd,
					ctrl: mem_ctrl, store_data: store_data};
			else
				exp_mem = bubble_entry();
		end
	end

	task automatic check_mem();
		addr_t exp_addr;
		exp_addr = (exp_mem.ctrl.load | exp_mem.ctrl.store) ? exp_mem.result : 32'h0;
		compare_hex("mem_stage_o", 80'(exp_mem), 80'(mem_stage));
		compare_hex("mem_addr_o", 80'(exp_addr), 80'(mem_addr));
		compare_hex("ex_valid_o", 80'(exp_valid), 80'(ex_valid));
	endtask

	// op_sel 15 and br_sel 6 mean no strobe
	task automatic apply_op(input data_t a, input data_t b, input int unsigned op_sel,
		input int unsigned br_sel, input logic valid, input logic ready);
		logic [$bits(alu_ctrl_t)-1:0] op_bits;
		logic [$bits(br_ctrl_t)-1:0] br_bits;
		@(negedge cpu_clk);
		check_mem();			// result of the previous edge
		op_bits = '0;
		br_bits = '0;
		if (op_sel < $bits(alu_ctrl_t))
			op_bits[op_sel] = 1'b1;
		if (br_sel < $bits(br_ctrl_t))
			br_bits[br_sel] = 1'b1;
		src1 = a;
		src2 = b;
		alu_ctrl = op_bits;
		br_ctrl = br_bits;
		mem_ctrl = 5'($urandom);	// load and store drive mem_addr_o
		store_data = $urandom;
		rd = 6'($urandom);
		dec_valid = valid;
		mem_ready = ready;
	endtask

	always @(dut_i.ex_stage_assert_i.fail_count)
		if (dut_i.ex_stage_assert_i.fail_count != 0)
			stop_on_error("concurrent assertion failed, see the error above");

	initial
	begin
		#((DIRECTED_OPS + RANDOM_OPS + 20) * 10 * 4);
		stop_on_error("timeout, the test sequence did not complete");
	end

	initial
	begin
		void'($urandom(32'hf6fb));	// single seed for the run
		cpu_rstn = 1'b0;
		dec_valid = 1'b0;
		src1 = '0;
		src2 = '0;
		alu_ctrl = '0;
		br_ctrl = '0;
		mem_ctrl = '0;
		store_data = '0;
		rd = '0;
		mem_ready = 1'b0;
		repeat (3) @(posedge cpu_clk);
		@(negedge cpu_clk);
		cpu_rstn = 1'b1;
		// zero, most negative, minus one, shift by 31
		for (int op = 0; op < 15; op++)
			for (int i = 0; i < CORNER_CNT; i++)
				for (int j = 0; j < CORNER_CNT; j++)
					apply_op(corner[i], corner[j], op, (i * CORNER_CNT + j) % 7, 1'b1, 1'b1);
		for (int n = 0; n < RANDOM_OPS; n++)
			apply_op($urandom, $urandom, $urandom_range(15, 0), $urandom_range(6, 0),
				$urandom_range(3, 0) != 0, $urandom_range(3, 0) != 0);
		apply_op('0, '0, 15, 6, 1'b0, 1'b1);	// bubble pushes out the last entry
		@(negedge cpu_clk);
		check_mem();
		if (dut_i.ex_stage_assert_i.fail_count != 0)
			stop_on_error("concurrent assertion failed, see the error above");
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// ==== all.f ====
+incdir+src
src/core_types_pkg.sv
src/ex_ctrl_pkg.sv
src/mul_unit.sv
src/alu_core.sv
src/branch_cond.sv
src/ex_mem_reg.sv
src/ex_stage.sv
tb/ex_stage_assert.sv
tb/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ex_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ex_stage_tb -o ex_stage_sim

status=0
./obj_dir/ex_stage_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
